//--- run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tb_rv_execute \
    -f rv_execute.f \
    -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Checks failed" sim.log; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
exit 0

//--- rv_execute.f
+incdir+src
src/rv_exec_pkg.sv
src/rv_imm_gen.sv
src/rv_alu.sv
src/rv_branch_cond.sv
src/rv_mem_access.sv
src/rv_execute.sv
tb/tb_rv_execute.sv

//--- src/rv_alu.sv
`include "rv_exec_defines.svh"

module rv_alu (
    input  logic                is_op,
    input  logic [2:0]          funct3,
    input  logic [6:0]          funct7,
    input  logic [`RV_XLEN-1:0] rs1,
    input  logic [`RV_XLEN-1:0] rs2,
    input  logic [`RV_XLEN-1:0] i_imm,
    output logic [`RV_XLEN-1:0] result,
    output logic                illegal
);

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    logic [`RV_XLEN-1:0] op_b;
    logic [4:0]          shamt;
    logic                is_sub;
    logic                lt_s;
    logic                lt_u;

    // Register form uses rs2, immediate form uses i_imm
    assign op_b  = is_op ? rs2 : i_imm;
    // For immediates this is instr[24:20]
    assign shamt = op_b[4:0];

    // SUB only exists in register form
    assign is_sub = is_op && (funct7 == F7_ALT);

    assign lt_s = $signed(rs1) < $signed(op_b);
    assign lt_u = rs1 < op_b;

    always_comb begin
        case (funct3)
            `RV_F3_ADD:  result = is_sub ? (rs1 - op_b) : (rs1 + op_b);
            `RV_F3_SLL:  result = rs1 << shamt;
            `RV_F3_SLT:  result = {{(`RV_XLEN-1){1'b0}}, lt_s};
            `RV_F3_SLTU: result = {{(`RV_XLEN-1){1'b0}}, lt_u};
            `RV_F3_XOR:  result = rs1 ^ op_b;
            `RV_F3_SR: begin
                // funct7 bit 5 selects arithmetic shift
                if (funct7[5]) begin
                    result = $unsigned($signed(rs1) >>> shamt);
                end else begin
                    result = rs1 >> shamt;
                end
            end
            `RV_F3_OR:   result = rs1 | op_b;
            default:     result = rs1 & op_b;
        endcase
    end

    // Allowed funct7 encodings per operation
    always_comb begin
        case (funct3)
            `RV_F3_ADD: illegal = is_op && (funct7 != F7_BASE) && (funct7 != F7_ALT);
            `RV_F3_SLL: illegal = (funct7 != F7_BASE);
            `RV_F3_SR:  illegal = (funct7 != F7_BASE) && (funct7 != F7_ALT);
            default:    illegal = is_op && (funct7 != F7_BASE);
        endcase
    end

endmodule

//--- src/rv_branch_cond.sv
`include "rv_exec_defines.svh"

module rv_branch_cond (
    input  logic [2:0]          funct3,
    input  logic [`RV_XLEN-1:0] rs1,
    input  logic [`RV_XLEN-1:0] rs2,
    output logic                taken,
    output logic                illegal
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (rs1 == rs2);
    assign lt_s = $signed(rs1) < $signed(rs2);
    assign lt_u = rs1 < rs2;

    always_comb begin
        illegal = 1'b0;
        case (funct3)
            `RV_F3_BEQ:  taken = eq;
            `RV_F3_BNE:  taken = !eq;
            `RV_F3_BLT:  taken = lt_s;
            `RV_F3_BGE:  taken = !lt_s;
            `RV_F3_BLTU: taken = lt_u;
            `RV_F3_BGEU: taken = !lt_u;
            default: begin
                // Codes 2 and 3 are unused
                taken   = 1'b0;
                illegal = 1'b1;
            end
        endcase
    end

endmodule

//--- src/rv_exec_defines.svh
`ifndef RV_EXEC_DEFINES_SVH
`define RV_EXEC_DEFINES_SVH

// Datapath widths
`define RV_XLEN                   32
`define RV_REG_AW                 5

// Exception cause codes
`define RV_CAUSE_ILLEGAL          5'd2
`define RV_CAUSE_LOAD_MISALIGNED  5'd4
`define RV_CAUSE_LOAD_FAULT       5'd5
`define RV_CAUSE_STORE_MISALIGNED 5'd6
`define RV_CAUSE_STORE_FAULT      5'd7

// ALU funct3
`define RV_F3_ADD                 3'b000
`define RV_F3_SLL                 3'b001
`define RV_F3_SLT                 3'b010
`define RV_F3_SLTU                3'b011
`define RV_F3_XOR                 3'b100
`define RV_F3_SR                  3'b101
`define RV_F3_OR                  3'b110
`define RV_F3_AND                 3'b111

// Branch funct3
`define RV_F3_BEQ                 3'b000
`define RV_F3_BNE                 3'b001
`define RV_F3_BLT                 3'b100
`define RV_F3_BGE                 3'b101
`define RV_F3_BLTU                3'b110
`define RV_F3_BGEU                3'b111

// Load and store sizes
`define RV_F3_LB                  3'b000
`define RV_F3_LH                  3'b001
`define RV_F3_LW                  3'b010
`define RV_F3_LBU                 3'b100
`define RV_F3_LHU                 3'b101

`endif

//--- src/rv_exec_pkg.sv
`include "rv_exec_defines.svh"

package rv_exec_pkg;

    // RV32I major opcodes, SYSTEM and MISC-MEM are decoded as illegal
    typedef enum logic [6:0] {
        OPC_LOAD     = 7'b0000011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_OP_IMM   = 7'b0010011,
        OPC_AUIPC    = 7'b0010111,
        OPC_STORE    = 7'b0100011,
        OPC_OP       = 7'b0110011,
        OPC_LUI      = 7'b0110111,
        OPC_BRANCH   = 7'b1100011,
        OPC_JALR     = 7'b1100111,
        OPC_JAL      = 7'b1101111,
        OPC_SYSTEM   = 7'b1110011
    } opcode_e;

    typedef enum logic [1:0] {
        CACHE_CMD_NONE  = 2'd0,
        CACHE_CMD_LOAD  = 2'd1,
        CACHE_CMD_STORE = 2'd2
    } cache_cmd_e;

    typedef enum logic [1:0] {
        CACHE_RSP_NONE         = 2'd0,
        CACHE_RSP_DONE         = 2'd1,
        CACHE_RSP_MISALIGNED   = 2'd2,
        CACHE_RSP_ACCESS_FAULT = 2'd3
    } cache_rsp_e;

    typedef struct packed {
        logic [`RV_XLEN-1:0] instr;
        logic [`RV_XLEN-1:0] pc;
    } fetch_req_t;

    typedef struct packed {
        logic                ready;
        logic                exc_start;
        logic                branch_taken;
        logic [`RV_XLEN-1:0] branch_target;
    } fetch_ctl_t;

    typedef struct packed {
        logic       valid;
        logic [4:0] cause;
    } exc_t;

    typedef struct packed {
        cache_cmd_e          cmd;
        logic [`RV_XLEN-1:0] addr;
        logic [2:0]          size;
        logic [`RV_XLEN-1:0] data;
    } cache_req_t;

    typedef struct packed {
        cache_rsp_e          rsp;
        logic [`RV_XLEN-1:0] data;
    } cache_rsp_t;

    typedef struct packed {
        logic [`RV_REG_AW-1:0] addr;
        logic [`RV_XLEN-1:0]   data;
        logic                  write;
    } rd_wb_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] i_imm;
        logic [`RV_XLEN-1:0] s_imm;
        logic [`RV_XLEN-1:0] b_imm;
        logic [`RV_XLEN-1:0] u_imm;
        logic [`RV_XLEN-1:0] j_imm;
    } imm_set_t;

endpackage

//--- src/rv_execute.sv
`include "rv_exec_defines.svh"

module rv_execute
    import rv_exec_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  fetch_req_t            fetch_req,
    output fetch_ctl_t            fetch_ctl,
    output exc_t                  exc,
    output logic [`RV_REG_AW-1:0] rs1_addr,
    input  logic [`RV_XLEN-1:0]   rs1_data,
    output logic [`RV_REG_AW-1:0] rs2_addr,
    input  logic [`RV_XLEN-1:0]   rs2_data,
    output rd_wb_t                rd_wb,
    output cache_req_t            cache_req,
    input  cache_rsp_t            cache_rsp
);

    typedef enum logic [2:0] {
        WB_ALU,
        WB_LOAD,
        WB_LUI,
        WB_AUIPC,
        WB_PC4
    } wb_sel_e;

    logic [`RV_XLEN-1:0] instr;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc_plus_4;
    opcode_e             opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    imm_set_t            imm;
    logic                is_op;
    logic                is_load;
    logic                is_store;
    logic [`RV_XLEN-1:0] alu_result;
    logic                alu_illegal;
    logic                br_taken;
    logic                br_illegal;
    logic                mem_illegal;
    logic                mem_done;
    exc_t                mem_fault;
    wb_sel_e             wb_sel;
    logic                wb_en;
    logic                illegal;

    // Instruction fields
    assign instr     = fetch_req.instr;
    assign pc        = fetch_req.pc;
    assign pc_plus_4 = pc + `RV_XLEN'd4;
    assign opcode    = opcode_e'(instr[6:0]);
    assign funct3    = instr[14:12];
    assign funct7    = instr[31:25];
    assign rs1_addr  = instr[19:15];
    assign rs2_addr  = instr[24:20];

    assign is_op    = (opcode == OPC_OP);
    assign is_load  = (opcode == OPC_LOAD);
    assign is_store = (opcode == OPC_STORE);

    rv_imm_gen u_imm_gen (
        .instr (instr),
        .imm   (imm)
    );

    rv_alu u_alu (
        .is_op   (is_op),
        .funct3  (funct3),
        .funct7  (funct7),
        .rs1     (rs1_data),
        .rs2     (rs2_data),
        .i_imm   (imm.i_imm),
        .result  (alu_result),
        .illegal (alu_illegal)
    );

    rv_branch_cond u_branch_cond (
        .funct3  (funct3),
        .rs1     (rs1_data),
        .rs2     (rs2_data),
        .taken   (br_taken),
        .illegal (br_illegal)
    );

    rv_mem_access u_mem_access (
        .clk      (clk),
        .rst_n    (rst_n),
        .is_load  (is_load),
        .is_store (is_store),
        .funct3   (funct3),
        .rs1      (rs1_data),
        .rs2      (rs2_data),
        .imm      (imm),
        .req      (cache_req),
        .rsp      (cache_rsp),
        .illegal  (mem_illegal),
        .done     (mem_done),
        .fault    (mem_fault)
    );

    // Main decode
    always_comb begin
        illegal                 = 1'b0;
        wb_sel                  = WB_ALU;
        wb_en                   = 1'b0;
        fetch_ctl.ready         = 1'b1;
        fetch_ctl.branch_taken  = 1'b0;
        fetch_ctl.branch_target = pc + imm.b_imm;
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                illegal = alu_illegal;
                wb_en   = 1'b1;
            end
            OPC_LUI: begin
                wb_sel = WB_LUI;
                wb_en  = 1'b1;
            end
            OPC_AUIPC: begin
                wb_sel = WB_AUIPC;
                wb_en  = 1'b1;
            end
            OPC_JAL: begin
                wb_sel                  = WB_PC4;
                wb_en                   = 1'b1;
                fetch_ctl.branch_taken  = 1'b1;
                fetch_ctl.branch_target = pc + imm.j_imm;
            end
            OPC_JALR: begin
                illegal                 = (funct3 != 3'b000);
                wb_sel                  = WB_PC4;
                wb_en                   = 1'b1;
                fetch_ctl.branch_taken  = !illegal;
                // Target LSB is always cleared
                fetch_ctl.branch_target = (rs1_data + imm.i_imm) & ~`RV_XLEN'd1;
            end
            OPC_BRANCH: begin
                illegal                = br_illegal;
                fetch_ctl.branch_taken = br_taken;
            end
            OPC_LOAD, OPC_STORE: begin
                illegal         = mem_illegal;
                wb_sel          = WB_LOAD;
                wb_en           = is_load && mem_done;
                // Stall until response or reported fault
                fetch_ctl.ready = mem_illegal || mem_done || mem_fault.valid;
            end
            default: begin
                // SYSTEM, MISC-MEM and unknown opcodes
                illegal = 1'b1;
            end
        endcase
    end

    // Writeback source
    always_comb begin
        case (wb_sel)
            WB_LOAD:  rd_wb.data = cache_rsp.data;
            WB_LUI:   rd_wb.data = imm.u_imm;
            WB_AUIPC: rd_wb.data = pc + imm.u_imm;
            WB_PC4:   rd_wb.data = pc_plus_4;
            default:  rd_wb.data = alu_result;
        endcase
    end

    assign rd_wb.addr  = instr[11:7];
    // x0 is never written
    assign rd_wb.write = wb_en && !illegal && (rd_wb.addr != '0);

    // Illegal instruction takes priority over a memory fault
    assign exc.valid           = illegal || mem_fault.valid;
    assign exc.cause           = illegal ? `RV_CAUSE_ILLEGAL : mem_fault.cause;
    assign fetch_ctl.exc_start = exc.valid;

    a_exc_ready: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_ctl.exc_start |-> fetch_ctl.ready);

endmodule

//--- src/rv_imm_gen.sv
`include "rv_exec_defines.svh"

module rv_imm_gen
    import rv_exec_pkg::*;
(
    input  logic [`RV_XLEN-1:0] instr,
    output imm_set_t            imm
);

    logic sign;

    // All formats take their sign from bit 31
    assign sign = instr[31];

    // I-type, loads, JALR and ALU immediates
    assign imm.i_imm = {{20{sign}}, instr[31:20]};

    // S-type splits the offset around rd
    assign imm.s_imm = {{20{sign}}, instr[31:25], instr[11:7]};

    // B-type offset, always even
    assign imm.b_imm = {{20{sign}},
                        instr[7],
                        instr[30:25],
                        instr[11:8],
                        1'b0};

    // U-type fills the upper 20 bits
    assign imm.u_imm = {instr[31:12], 12'h000};

    // J-type offset for JAL
    assign imm.j_imm = {{12{sign}},
                        instr[19:12],
                        instr[20],
                        instr[30:25],
                        instr[24:21],
                        1'b0};

endmodule

//--- src/rv_mem_access.sv
`include "rv_exec_defines.svh"

module rv_mem_access
    import rv_exec_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                is_load,
    input  logic                is_store,
    input  logic [2:0]          funct3,
    input  logic [`RV_XLEN-1:0] rs1,
    input  logic [`RV_XLEN-1:0] rs2,
    input  imm_set_t            imm,
    output cache_req_t          req,
    input  cache_rsp_t          rsp,
    output logic                illegal,
    output logic                done,
    output exc_t                fault
);

    logic       issued;
    logic       fault_pend;
    logic [4:0] fault_cause;
    logic       load_ok;
    logic       active;
    logic       rsp_done;
    logic       rsp_err;
    logic       rsp_misaligned;

    // Valid load sizes
    always_comb begin
        case (funct3)
            `RV_F3_LB, `RV_F3_LH, `RV_F3_LW, `RV_F3_LBU, `RV_F3_LHU: load_ok = 1'b1;
            default: load_ok = 1'b0;
        endcase
    end

    assign illegal = (is_load && !load_ok) || (is_store && funct3[2]);
    assign active  = (is_load || is_store) && !illegal;

    // Responses only count once the command has been seen by the cache
    assign rsp_done       = issued && (rsp.rsp == CACHE_RSP_DONE);
    assign rsp_misaligned = rsp.rsp == CACHE_RSP_MISALIGNED;
    assign rsp_err        = issued && (rsp_misaligned || (rsp.rsp == CACHE_RSP_ACCESS_FAULT));

    // Command drops in the response cycle and while the fault is reported
    always_comb begin
        req.cmd = CACHE_CMD_NONE;
        if (active && !fault_pend && !rsp_done && !rsp_err) begin
            req.cmd = is_load ? CACHE_CMD_LOAD : CACHE_CMD_STORE;
        end
    end

    assign req.addr = rs1 + (is_store ? imm.s_imm : imm.i_imm);
    assign req.size = funct3;
    assign req.data = rs2;

    assign done        = rsp_done;
    assign fault.valid = fault_pend;
    assign fault.cause = fault_cause;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issued     <= 1'b0;
            fault_pend <= 1'b0;
        end else if (fault_pend) begin
            // Fault reported this cycle, instruction retires
            issued     <= 1'b0;
            fault_pend <= 1'b0;
        end else if (rsp_done) begin
            issued <= 1'b0;
        end else if (rsp_err) begin
            issued     <= 1'b0;
            fault_pend <= 1'b1;
        end else if (active) begin
            issued <= 1'b1;
        end
    end

    // Cause held for the reporting cycle
    always_ff @(posedge clk) begin
        if (rsp_err) begin
            if (is_load) begin
                fault_cause <= rsp_misaligned ? `RV_CAUSE_LOAD_MISALIGNED : `RV_CAUSE_LOAD_FAULT;
            end else begin
                fault_cause <= rsp_misaligned ? `RV_CAUSE_STORE_MISALIGNED
                                              : `RV_CAUSE_STORE_FAULT;
            end
        end
    end

    a_rsp_needs_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp.rsp != CACHE_RSP_NONE) |-> issued);

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (req.cmd != CACHE_CMD_NONE) |=> (rsp.rsp != CACHE_RSP_NONE) || $stable(req));

    a_done_fault_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(done && fault.valid));

endmodule

//--- tb/tb_rv_execute.sv
`include "rv_exec_defines.svh"

module tb_rv_execute
    import rv_exec_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_INSTR        = 400;
    localparam int TIMEOUT_CYCLES = N_INSTR * 8 + 16 + 2;

    logic                  clk;
    logic                  rst_n;
    fetch_req_t            fetch_req;
    fetch_ctl_t            fetch_ctl;
    exc_t                  exc;
    logic [`RV_REG_AW-1:0] rs1_addr;
    logic [`RV_REG_AW-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;
    rd_wb_t                rd_wb;
    cache_req_t            cache_req;
    cache_rsp_t            cache_rsp;

    logic [31:0] regs [32];
    logic [31:0] mem [256];
    logic [31:0] rng;
    string       test_name;
    logic        active;

    // Expected DUT outputs for the current cycle
    logic        exp_ready;
    logic        exp_write;
    logic [4:0]  exp_rd;
    logic [31:0] exp_data;
    logic        exp_taken;
    logic        exp_tchk;
    logic [31:0] exp_target;
    logic        exp_exc;
    logic [4:0]  exp_cause;
    cache_cmd_e  exp_cmd;
    logic [31:0] exp_addr;
    logic [2:0]  exp_size;
    logic [31:0] exp_sdata;

    rv_execute u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_req (fetch_req),
        .fetch_ctl (fetch_ctl),
        .exc       (exc),
        .rs1_addr  (rs1_addr),
        .rs1_data  (rs1_data),
        .rs2_addr  (rs2_addr),
        .rs2_data  (rs2_data),
        .rd_wb     (rd_wb),
        .cache_req (cache_req),
        .cache_rsp (cache_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Register file model, x0 stays zero
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= (i == 0) ? 32'h0 : (32'(i) * 32'h9E3779B9) ^ 32'h2097ACE1;
            end
        end else if (rd_wb.write && rd_wb.addr != 5'd0) begin
            regs[rd_wb.addr] <= rd_wb.data;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_random(output logic [31:0] v);
        rng = xorshift32(rng);
        v   = rng;
    endtask

    function automatic logic [31:0] sext12(input logic [11:0] x);
        return {{20{x[11]}}, x};
    endfunction

    // Integer result per RV32I rules, alt selects SUB or SRA
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic ref_branch(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // Cache returns the loaded value already extended
    function automatic logic [31:0] load_value(input logic [31:0] addr, input logic [2:0] f3);
        logic [31:0] w;
        logic [31:0] s;
        w = mem[addr[9:2]];
        s = w >> {addr[1:0], 3'b000};
        case (f3[1:0])
            2'b00:   return f3[2] ? {24'h0, s[7:0]} : {{24{s[7]}}, s[7:0]};
            2'b01:   return f3[2] ? {16'h0, s[15:0]} : {{16{s[15]}}, s[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic logic [31:0] store_merge(input logic [31:0] old, input logic [31:0] addr,
                                                input logic [31:0] data, input logic [2:0] f3);
        logic [31:0] mask;
        logic [4:0]  sh;
        sh = {addr[1:0], 3'b000};
        case (f3[1:0])
            2'b00:   mask = 32'h000000ff;
            2'b01:   mask = 32'h0000ffff;
            default: mask = 32'hffffffff;
        endcase
        mask = mask << sh;
        return (old & ~mask) | ((data << sh) & mask);
    endfunction

    task automatic report_mismatch(input string check, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("error: %s %s expected %h actual %h", test_name, check, exp, act);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("%s during %s", what, test_name);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic set_exp_default();
        exp_ready  = 1'b1;
        exp_write  = 1'b0;
        exp_rd     = 5'd0;
        exp_data   = 32'h0;
        exp_taken  = 1'b0;
        exp_tchk   = 1'b0;
        exp_target = 32'h0;
        exp_exc    = 1'b0;
        exp_cause  = 5'd0;
        exp_cmd    = CACHE_CMD_NONE;
        exp_addr   = 32'h0;
        exp_size   = 3'b000;
        exp_sdata  = 32'h0;
    endtask

    // One-cycle instructions, kind 8 is an illegal encoding
    task automatic run_simple(input int kind);
        logic [31:0] r;
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] instr;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm12;
        logic [20:0] j21;
        logic [12:0] b13;
        next_random(r);
        rs1   = r[4:0];
        rs2   = r[9:5];
        rd    = r[14:10];
        f3    = r[17:15];
        alt   = r[18];
        imm12 = r[30:19];
        next_random(r);
        pc = {16'h0, r[15:2], 2'b00};
        a  = regs[rs1];
        b  = regs[rs2];
        set_exp_default();
        exp_write = (rd != 5'd0);
        exp_rd    = rd;
        case (kind)
            0: begin
                test_name = "alu_reg";
                alt       = alt && (f3 == 3'b000 || f3 == 3'b101);
                instr     = {alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, OPC_OP};
                exp_data  = ref_alu(f3, alt, a, b);
            end
            1: begin
                test_name = "alu_imm";
                // Shift immediates carry funct7 in the upper bits
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    imm12 = {1'b0, alt && f3 == 3'b101, 5'b0, imm12[4:0]};
                end
                instr    = {imm12, rs1, f3, rd, OPC_OP_IMM};
                exp_data = ref_alu(f3, f3 == 3'b101 && imm12[10], a, sext12(imm12));
            end
            2: begin
                test_name = "lui";
                instr     = {r[31:12], rd, OPC_LUI};
                exp_data  = {r[31:12], 12'h000};
            end
            3: begin
                test_name = "auipc";
                instr     = {r[31:12], rd, OPC_AUIPC};
                exp_data  = pc + {r[31:12], 12'h000};
            end
            4: begin
                test_name  = "jal";
                j21        = {r[31:12], 1'b0};
                instr      = {j21[20], j21[10:1], j21[11], j21[19:12], rd, OPC_JAL};
                exp_data   = pc + 32'd4;
                exp_taken  = 1'b1;
                exp_tchk   = 1'b1;
                exp_target = pc + {{11{j21[20]}}, j21};
            end
            5: begin
                test_name  = "jalr";
                instr      = {imm12, rs1, 3'b000, rd, OPC_JALR};
                exp_data   = pc + 32'd4;
                exp_taken  = 1'b1;
                exp_tchk   = 1'b1;
                exp_target = (a + sext12(imm12)) & ~32'd1;
            end
            6: begin
                test_name = "branch";
                if (f3[2:1] == 2'b01) begin
                    f3[2] = 1'b1;
                end
                b13        = {imm12, 1'b0};
                instr      = {b13[12], b13[10:5], rs2, rs1, f3, b13[4:1], b13[11], OPC_BRANCH};
                exp_write  = 1'b0;
                exp_taken  = ref_branch(f3, a, b);
                exp_tchk   = 1'b1;
                exp_target = pc + {{19{b13[12]}}, b13};
            end
            default: begin
                test_name = "illegal";
                exp_write = 1'b0;
                exp_exc   = 1'b1;
                exp_cause = `RV_CAUSE_ILLEGAL;
                case (r[18:16])
                    3'd0: instr = {imm12, rs1, 3'b000, rd, OPC_SYSTEM};
                    3'd1: instr = {imm12, rs1, 3'b000, rd, OPC_MISC_MEM};
                    3'd2: instr = {imm12, rs1, f3, rd, 7'b1111111};
                    3'd3: instr = {7'b0000001, rs2, rs1, f3, rd, OPC_OP};
                    3'd4: instr = {imm12[11:5], rs2, rs1, 2'b01, alt, imm12[4:0], OPC_BRANCH};
                    3'd5: instr = {imm12, rs1, (f3 == 3'b000) ? 3'b001 : f3, rd, OPC_JALR};
                    3'd6: instr = {imm12, rs1, f3[2] ? {2'b11, f3[0]} : 3'b011, rd, OPC_LOAD};
                    default: instr = {imm12[11:5], rs2, rs1, 1'b1, f3[1:0], imm12[4:0], OPC_STORE};
                endcase
            end
        endcase
        fetch_req.instr = instr;
        fetch_req.pc    = pc;
        active          = 1'b1;
        @(negedge clk);
    endtask

    task automatic run_mem(input logic is_store);
        logic [31:0] r;
        logic [31:0] pc;
        logic [31:0] addr;
        logic [31:0] off;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [11:0] imm12;
        logic        mis;
        int          delay;
        next_random(r);
        rs2 = r[9:5];
        rd  = r[14:10];
        if (is_store) begin
            f3 = {1'b0, (r[17:16] == 2'b11) ? 2'b10 : r[17:16]};
        end else begin
            f3 = r[18:16];
            if (f3 == 3'd3 || f3 == 3'd6 || f3 == 3'd7) begin
                f3 = 3'b010;
            end
        end
        // Offsets above 1023 reach past the memory model
        off   = r % 32'd1152;
        imm12 = off[11:0];
        if (!r[20]) begin
            imm12[0] = imm12[0] && (f3[1:0] == 2'b00);
            imm12[1] = imm12[1] && (f3[1:0] != 2'b10);
        end
        rs1 = (r[23:21] == 3'b000) ? r[28:24] : 5'd0;
        next_random(r);
        pc    = {16'h0, r[15:2], 2'b00};
        delay = 1 + int'(r[17:16]);
        addr  = regs[rs1] + sext12(imm12);
        mis   = (f3[1:0] == 2'b01 && addr[0]) || (f3[1:0] == 2'b10 && addr[1:0] != 2'b00);
        set_exp_default();
        test_name = is_store ? "store" : "load";
        exp_ready = 1'b0;
        exp_rd    = rd;
        exp_cmd   = is_store ? CACHE_CMD_STORE : CACHE_CMD_LOAD;
        exp_addr  = addr;
        exp_size  = f3;
        exp_sdata = regs[rs2];
        if (is_store) begin
            fetch_req.instr = {imm12[11:5], rs2, rs1, f3, imm12[4:0], OPC_STORE};
        end else begin
            fetch_req.instr = {imm12, rs1, f3, rd, OPC_LOAD};
        end
        fetch_req.pc = pc;
        active       = 1'b1;
        repeat (delay) @(negedge clk);
        exp_cmd = CACHE_CMD_NONE;
        if (mis || addr >= 32'd1024) begin
            cache_rsp.rsp = mis ? CACHE_RSP_MISALIGNED : CACHE_RSP_ACCESS_FAULT;
            @(negedge clk);
            cache_rsp.rsp = CACHE_RSP_NONE;
            exp_ready     = 1'b1;
            exp_exc       = 1'b1;
            if (is_store) begin
                exp_cause = mis ? `RV_CAUSE_STORE_MISALIGNED : `RV_CAUSE_STORE_FAULT;
            end else begin
                exp_cause = mis ? `RV_CAUSE_LOAD_MISALIGNED : `RV_CAUSE_LOAD_FAULT;
            end
            @(negedge clk);
        end else begin
            cache_rsp.rsp = CACHE_RSP_DONE;
            exp_ready     = 1'b1;
            if (is_store) begin
                mem[addr[9:2]] = store_merge(mem[addr[9:2]], addr, regs[rs2], f3);
            end else begin
                cache_rsp.data = load_value(addr, f3);
                exp_write      = (rd != 5'd0);
                exp_data       = cache_rsp.data;
            end
            @(negedge clk);
            cache_rsp.rsp = CACHE_RSP_NONE;
        end
    endtask

    initial begin : stimulus
        logic [31:0] r;
        int          kind;
        rst_n           = 1'b0;
        active          = 1'b0;
        rng             = 32'h2097;
        test_name       = "reset";
        fetch_req.instr = 32'h00000013;
        fetch_req.pc    = 32'h0;
        cache_rsp.rsp   = CACHE_RSP_NONE;
        cache_rsp.data  = 32'h0;
        set_exp_default();
        for (int i = 0; i < 256; i++) begin
            mem[i] = (32'(i) * 32'h01000193) ^ 32'h5A5A0F0F;
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        for (int n = 0; n < N_INSTR; n++) begin
            next_random(r);
            kind = int'(r % 32'd9);
            if (kind == 7) begin
                run_mem(r[3]);
            end else begin
                run_simple(kind);
            end
        end
        active = 1'b0;
        $display("All checks passed");
        $finish;
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the instruction sequence did not complete in time");
        $display("Checks failed");
        $fatal(1);
    end

    a_ready: assert property (@(posedge clk) disable iff (!rst_n)
        active |-> fetch_ctl.ready == exp_ready)
        else report_mismatch("ready", 32'(exp_ready), 32'($sampled(fetch_ctl.ready)));

    a_write: assert property (@(posedge clk) disable iff (!rst_n)
        active |-> rd_wb.write == exp_write)
        else report_mismatch("write", 32'(exp_write), 32'($sampled(rd_wb.write)));

    a_rd_addr: assert property (@(posedge clk) disable iff (!rst_n)
        active && exp_write |-> rd_wb.addr == exp_rd)
        else report_mismatch("rd addr", 32'(exp_rd), 32'($sampled(rd_wb.addr)));

    a_data: assert property (@(posedge clk) disable iff (!rst_n)
        active && exp_write |-> rd_wb.data == exp_data)
        else report_mismatch("rd data", exp_data, $sampled(rd_wb.data));

    a_taken: assert property (@(posedge clk) disable iff (!rst_n)
        active |-> fetch_ctl.branch_taken == exp_taken)
        else report_mismatch("taken", 32'(exp_taken), 32'($sampled(fetch_ctl.branch_taken)));

    a_target: assert property (@(posedge clk) disable iff (!rst_n)
        active && exp_tchk |-> fetch_ctl.branch_target == exp_target)
        else report_mismatch("target", exp_target, $sampled(fetch_ctl.branch_target));

    a_exc: assert property (@(posedge clk) disable iff (!rst_n)
        active |-> exc.valid == exp_exc && fetch_ctl.exc_start == exp_exc)
        else report_mismatch("exception", 32'(exp_exc), 32'($sampled(exc.valid)));

    a_cause: assert property (@(posedge clk) disable iff (!rst_n)
        active && exp_exc |-> exc.cause == exp_cause)
        else report_mismatch("cause", 32'(exp_cause), 32'($sampled(exc.cause)));

    a_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        active |-> cache_req.cmd == exp_cmd)
        else report_mismatch("cache cmd", 32'(exp_cmd), 32'($sampled(cache_req.cmd)));

    a_addr: assert property (@(posedge clk) disable iff (!rst_n)
        active && exp_cmd != CACHE_CMD_NONE |-> cache_req.addr == exp_addr)
        else report_mismatch("cache addr", exp_addr, $sampled(cache_req.addr));

    a_size: assert property (@(posedge clk) disable iff (!rst_n)
        active && exp_cmd != CACHE_CMD_NONE |-> cache_req.size == exp_size)
        else report_mismatch("cache size", 32'(exp_size), 32'($sampled(cache_req.size)));

    a_sdata: assert property (@(posedge clk) disable iff (!rst_n)
        active && exp_cmd == CACHE_CMD_STORE |-> cache_req.data == exp_sdata)
        else report_mismatch("store data", exp_sdata, $sampled(cache_req.data));

    a_no_x0: assert property (@(posedge clk) disable iff (!rst_n)
        rd_wb.write |-> rd_wb.addr != 5'd0)
        else report_failure("The DUT wrote register x0");

endmodule
